/* ps2_key_display.f */
+incdir+design
design/ps2_pkg.sv
design/ps2_frame_if.sv
design/ps2_rx.sv
design/scan_to_ascii.sv
design/key_tracker.sv
design/seg_display.sv
design/ps2_key_display.sv
bench/tb_ps2_key_display.sv

/* Makefile */
TOP := tb_ps2_key_display
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

obj_dir/V$(TOP): ps2_key_display.f $(wildcard design/*.sv design/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f ps2_key_display.f \
		--top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f ps2_key_display.f --top-module ps2_key_display

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_ps2_key_display.sv */
`timescale 1ns/10ps
`include "ps2_defines.svh"

module tb_ps2_key_display import ps2_pkg::*; ();

	localparam int KB_CYCLES = 16;
	localparam int PRESS_KEYS = 16;
	localparam int TYPE_KEYS = 6;
	localparam int MAX_REPEATS = 6;
	localparam int BAD_FRAMES = 12;
	localparam int WRAP_FRAMES = 240;
	// upper bound on frames sent by all tests.
	localparam int MAX_FRAMES = PRESS_KEYS * 3 + TYPE_KEYS * (MAX_REPEATS + 3) + 7
		+ 1 + BAD_FRAMES + WRAP_FRAMES;
	localparam longint WATCHDOG_NS = longint'(MAX_FRAMES) * `PS2_FRAME_BITS * KB_CYCLES
		* 100 * 2;

	logic                     clk = 1'b0;
	logic                     resetn;
	logic                     ps2_clk;
	logic                     ps2_data;
	scan_code_t               key_code;
	ascii_t                   key_ascii;
	press_count_t             press_count;
	logic                     key_held;
	logic                     rx_error;
	logic [`SEG_DIGITS*7-1:0] segments;

	// reference model state.
	scan_code_t   m_code;
	ascii_t       m_ascii;
	press_count_t m_count;
	logic         m_held;
	logic         m_break;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int rx_pulses = 0;

	// a-z, 0-9, space, enter.
	scan_code_t key_table [38] = '{
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
		8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
		8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
		8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
		8'h29, 8'h5A
	};

	always #50 clk = ~clk;

	ps2_key_display u_ps2_key_display (
		.clk         (clk),
		.resetn      (resetn),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.key_code    (key_code),
		.key_ascii   (key_ascii),
		.press_count (press_count),
		.key_held    (key_held),
		.rx_error    (rx_error),
		.segments    (segments)
	);

	always @(posedge clk) begin
		if (resetn && rx_error) begin
			rx_pulses <= rx_pulses + 1;
		end
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic ascii_t ascii_of(scan_code_t code);
		ascii_t a;
		a = 8'h00;
		for (int i = 0; i < 38; i++) begin
			if (key_table[i] == code) begin
				if (i < 26) begin
					a = 8'h61 + 8'(i);
				end else if (i < 36) begin
					a = 8'h30 + 8'(i - 26);
				end else if (i == 36) begin
					a = 8'h20;
				end else begin
					a = 8'h0D;
				end
			end
		end
		return a;
	endfunction

	// gfedcba.
	function automatic seg_pattern_t seg_of(logic [3:0] nib);
		case (nib)
			4'h0: return 7'b0111111;
			4'h1: return 7'b0000110;
			4'h2: return 7'b1011011;
			4'h3: return 7'b1001111;
			4'h4: return 7'b1100110;
			4'h5: return 7'b1101101;
			4'h6: return 7'b1111101;
			4'h7: return 7'b0000111;
			4'h8: return 7'b1111111;
			4'h9: return 7'b1101111;
			4'hA: return 7'b1110111;
			4'hB: return 7'b1111100;
			4'hC: return 7'b0111001;
			4'hD: return 7'b1011110;
			4'hE: return 7'b1111001;
			default: return 7'b1110001;
		endcase
	endfunction

	function automatic logic [`SEG_DIGITS*7-1:0] expected_segments();
		logic [`SEG_DIGITS*4-1:0] nibs;
		logic [`SEG_DIGITS*7-1:0] segs;
		nibs = {m_count, m_ascii, m_code};
		for (int d = 0; d < `SEG_DIGITS; d++) begin
			segs[d*7 +: 7] = (d < 4 && !m_held) ? 7'h00 : seg_of(nibs[d*4 +: 4]);
		end
		return segs;
	endfunction

	task automatic model_apply(scan_code_t code);
		if (code == `PS2_BREAK_CODE) begin
			m_break = 1'b1;
		end else if (code != `PS2_EXT_CODE) begin
			if (m_break) begin
				m_break = 1'b0;
				if (m_held && code == m_code) begin
					m_held = 1'b0;
				end
			end else if (!m_held || code != m_code) begin
				m_code = code;
				m_ascii = ascii_of(code);
				m_held = 1'b1;
				m_count = m_count + 8'd1;
			end
		end
	endtask

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_code(string name, scan_code_t exp, scan_code_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_ascii(string name, ascii_t exp, ascii_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_count(string name, press_count_t exp, press_count_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_segments(string name, logic [`SEG_DIGITS*7-1:0] exp,
			logic [`SEG_DIGITS*7-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_outputs();
		check_code("key_code", m_code, key_code);
		check_ascii("key_ascii", m_ascii, key_ascii);
		check_count("press_count", m_count, press_count);
		check_bit("key_held", m_held, key_held);
		check_bit("rx_error", 1'b0, rx_error);
		check_segments("segments", expected_segments(), segments);
	endtask

	//////////////////////////////
	// keyboard side
	//////////////////////////////

	// start, data lsb first, odd parity, stop.
	task automatic send_frame(scan_code_t code, logic bad_parity, logic bad_stop);
		logic [10:0] bits;
		bits = {~bad_stop, ~(^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
			ps2_data = bits[i];
			repeat (KB_CYCLES / 4) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (KB_CYCLES / 2) @(negedge clk);
			ps2_clk = 1'b1;
			repeat (KB_CYCLES / 4) @(negedge clk);
		end
		ps2_data = 1'b1;
		repeat (2 * KB_CYCLES) @(negedge clk);
	endtask

	task automatic key_event(scan_code_t code);
		send_frame(code, 1'b0, 1'b0);
		model_apply(code);
		check_outputs();
	endtask

	function automatic scan_code_t pick_key();
		return key_table[$urandom_range(37, 0)];
	endfunction

	function automatic scan_code_t pick_other(scan_code_t avoid);
		scan_code_t c;
		c = pick_key();
		while (c == avoid) begin
			c = pick_key();
		end
		return c;
	endfunction

	task automatic finish_test(string name, int errs_before);
		tests++;
		$display("test %s done, %0d errors", name, errors - errs_before);
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	initial begin
		scan_code_t a;
		scan_code_t b;
		int base;
		int pulses_before;
		logic bad;
		void'($urandom(32'hc634f5bc));
		resetn = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		m_code = '0;
		m_ascii = '0;
		m_count = '0;
		m_held = 1'b0;
		m_break = 1'b0;
		repeat (3) @(negedge clk);
		resetn = 1'b1;
		repeat (2) @(negedge clk);

		base = errors;
		check_outputs();
		finish_test("reset", base);

		base = errors;
		for (int i = 0; i < PRESS_KEYS; i++) begin
			a = pick_key();
			key_event(a);
			// hold time.
			repeat ($urandom_range(3, 0) * KB_CYCLES) @(negedge clk);
			key_event(`PS2_BREAK_CODE);
			key_event(a);
		end
		finish_test("press_release", base);

		base = errors;
		for (int i = 0; i < TYPE_KEYS; i++) begin
			a = pick_key();
			key_event(a);
			repeat ($urandom_range(MAX_REPEATS, 1)) key_event(a);
			key_event(`PS2_BREAK_CODE);
			key_event(a);
		end
		finish_test("typematic", base);

		base = errors;
		a = pick_key();
		b = pick_other(a);
		key_event(a);
		key_event(b);
		key_event(`PS2_BREAK_CODE);
		key_event(a);
		key_event(`PS2_EXT_CODE);
		key_event(`PS2_BREAK_CODE);
		key_event(b);
		finish_test("rollover", base);

		base = errors;
		key_event(pick_key());
		pulses_before = rx_pulses;
		for (int i = 0; i < BAD_FRAMES; i++) begin
			bad = 1'($urandom_range(1, 0));
			send_frame(pick_key(), bad, !bad);
			check_outputs();
		end
		checks++;
		if (rx_pulses - pulses_before != BAD_FRAMES) begin
			errors++;
			$display("rx_error pulsed %0d times for %0d corrupted frames",
				rx_pulses - pulses_before, BAD_FRAMES);
		end
		finish_test("corrupted", base);

		// enough presses to wrap the count.
		base = errors;
		for (int i = 0; i < WRAP_FRAMES; i++) begin
			key_event(pick_other(m_code));
		end
		finish_test("display_wrap", base);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns with tests still running", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

/* design/ps2_key_display.sv */
`timescale 1ns/10ps
`include "ps2_defines.svh"

module ps2_key_display (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   ps2_clk,
	input  logic                   ps2_data,
	output logic [7:0]             key_code,
	output logic [7:0]             key_ascii,
	output logic [7:0]             press_count,
	output logic                   key_held,
	output logic                   rx_error,
	output logic [`SEG_DIGITS*7-1:0] segments
);

	ps2_frame_if u_frame_if ();

	ps2_rx u_ps2_rx (
		.clk      (clk),
		.resetn   (resetn),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_error (rx_error),
		.frame    (u_frame_if.rx)
	);

	key_tracker u_key_tracker (
		.clk         (clk),
		.resetn      (resetn),
		.frame       (u_frame_if.sink),
		.key_code    (key_code),
		.key_ascii   (key_ascii),
		.press_count (press_count),
		.key_held    (key_held)
	);

	// digit 0 lands in segments[6:0].
	seg_display u_seg_display (
		.clk         (clk),
		.resetn      (resetn),
		.key_code    (key_code),
		.key_ascii   (key_ascii),
		.press_count (press_count),
		.key_held    (key_held),
		.segments    (segments)
	);

endmodule

/* design/seg_display.sv */
`timescale 1ns/10ps
`include "ps2_defines.svh"

module seg_display import ps2_pkg::*; (
	input  logic                             clk,
	input  logic                             resetn,
	input  scan_code_t                       key_code,
	input  ascii_t                           key_ascii,
	input  press_count_t                     press_count,
	input  logic                             key_held,
	output seg_pattern_t [`SEG_DIGITS-1:0]   segments
);

	logic [`SEG_DIGITS*4-1:0]       nibbles;
	seg_pattern_t [`SEG_DIGITS-1:0] patterns;

	// common a-g encoding, b and d in lower case.
	function automatic seg_pattern_t hex_to_seg(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'h3F;
			4'h1: return 7'h06;
			4'h2: return 7'h5B;
			4'h3: return 7'h4F;
			4'h4: return 7'h66;
			4'h5: return 7'h6D;
			4'h6: return 7'h7D;
			4'h7: return 7'h07;
			4'h8: return 7'h7F;
			4'h9: return 7'h6F;
			4'hA: return 7'h77;
			4'hB: return 7'h7C;
			4'hC: return 7'h39;
			4'hD: return 7'h5E;
			4'hE: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	// digit 0 is the low nibble of the scan code.
	assign nibbles = {press_count, key_ascii, key_code};

	// key digits go dark when nothing is held.
	always_comb begin
		for (int d = 0; d < `SEG_DIGITS; d++) begin
			patterns[d] = hex_to_seg(nibbles[d*4 +: 4]);
			if (d < 4 && !key_held) begin
				patterns[d] = '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			segments <= '0;
		end else begin
			segments <= patterns;
		end
	end

endmodule

/* design/key_tracker.sv */
`timescale 1ns/10ps
`include "ps2_defines.svh"

module key_tracker import ps2_pkg::*; (
	input  logic         clk,
	input  logic         resetn,
	ps2_frame_if.sink    frame,
	output scan_code_t   key_code,
	output ascii_t       key_ascii,
	output press_count_t press_count,
	output logic         key_held
);

	tracker_state_e state;
	tracker_state_e state_next;
	ascii_t         ascii_lookup;
	logic           is_key;
	logic           in_break;
	logic           new_press;
	logic           release_key;

	scan_to_ascii u_scan_to_ascii (
		.code  (frame.code),
		.ascii (ascii_lookup)
	);

	//////////////////////////////
	// frame decode
	//////////////////////////////

	// prefixes are not keys. E0 is dropped entirely.
	assign is_key = frame.frame_valid
		&& (frame.code != `PS2_EXT_CODE)
		&& (frame.code != `PS2_BREAK_CODE);

	assign in_break = (state == track_break_idle) || (state == track_break_held);
	assign key_held = (state == track_held) || (state == track_break_held);

	// same code while held is typematic repeat.
	assign new_press = is_key && !in_break && (!key_held || frame.code != key_code);
	assign release_key = is_key && (state == track_break_held) && (frame.code == key_code);

	always_comb begin
		state_next = state;
		if (frame.frame_valid && frame.code == `PS2_BREAK_CODE) begin
			state_next = key_held ? track_break_held : track_break_idle;
		end else if (is_key) begin
			case (state)
				track_break_held: state_next = release_key ? track_idle : track_held;
				track_break_idle: state_next = track_idle;
				default: begin
					if (new_press) begin
						state_next = track_held;
					end
				end
			endcase
		end
	end

	//////////////////////////////
	// state and key registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= track_idle;
			key_code <= '0;
			key_ascii <= '0;
			press_count <= '0;
		end else begin
			state <= state_next;
			// last key stays visible after release.
			if (new_press) begin
				key_code <= frame.code;
				key_ascii <= ascii_lookup;
				press_count <= press_count + 8'd1;
			end
		end
	end

	a_count_after_frame: assert property (@(posedge clk) disable iff (!resetn)
		$changed(press_count) |-> $past(frame.frame_valid));

	a_hold_with_press: assert property (@(posedge clk) disable iff (!resetn)
		$rose(key_held) |-> $changed(press_count));

endmodule

/* design/scan_to_ascii.sv */
`timescale 1ns/10ps

module scan_to_ascii import ps2_pkg::*; (
	input  scan_code_t code,
	output ascii_t     ascii
);

	// set-2 make codes, lower case only.
	always_comb begin
		case (code)
			// letters.
			8'h1C: ascii = 8'h61;
			8'h32: ascii = 8'h62;
			8'h21: ascii = 8'h63;
			8'h23: ascii = 8'h64;
			8'h24: ascii = 8'h65;
			8'h2B: ascii = 8'h66;
			8'h34: ascii = 8'h67;
			8'h33: ascii = 8'h68;
			8'h43: ascii = 8'h69;
			8'h3B: ascii = 8'h6A;
			8'h42: ascii = 8'h6B;
			8'h4B: ascii = 8'h6C;
			8'h3A: ascii = 8'h6D;
			8'h31: ascii = 8'h6E;
			8'h44: ascii = 8'h6F;
			8'h4D: ascii = 8'h70;
			8'h15: ascii = 8'h71;
			8'h2D: ascii = 8'h72;
			8'h1B: ascii = 8'h73;
			8'h2C: ascii = 8'h74;
			8'h3C: ascii = 8'h75;
			8'h2A: ascii = 8'h76;
			8'h1D: ascii = 8'h77;
			8'h22: ascii = 8'h78;
			8'h35: ascii = 8'h79;
			8'h1A: ascii = 8'h7A;
			// top-row digits.
			8'h45: ascii = 8'h30;
			8'h16: ascii = 8'h31;
			8'h1E: ascii = 8'h32;
			8'h26: ascii = 8'h33;
			8'h25: ascii = 8'h34;
			8'h2E: ascii = 8'h35;
			8'h36: ascii = 8'h36;
			8'h3D: ascii = 8'h37;
			8'h3E: ascii = 8'h38;
			8'h46: ascii = 8'h39;
			// space and enter.
			8'h29: ascii = 8'h20;
			8'h5A: ascii = 8'h0D;
			default: ascii = 8'h00;
		endcase
	end

endmodule

/* design/ps2_rx.sv */
`timescale 1ns/10ps
`include "ps2_defines.svh"

module ps2_rx (
	input  logic    clk,
	input  logic    resetn,
	input  logic    ps2_clk,
	input  logic    ps2_data,
	output logic    rx_error,
	ps2_frame_if.rx frame
);

	localparam int LAST_STAGE = `PS2_SYNC_STAGES - 1;
	localparam int LAST_BIT = `PS2_FRAME_BITS - 1;

	logic [`PS2_SYNC_STAGES-1:0] clk_sync;
	logic [`PS2_SYNC_STAGES-1:0] data_sync;
	logic                        clk_prev;
	logic                        fall;
	logic                        data_bit;
	logic [3:0]                  bit_cnt;
	logic [`PS2_FRAME_BITS-2:0]  shift;
	logic                        frame_end;
	logic                        framing_ok;
	logic                        parity_ok;

	//////////////////////////////
	// synchroniser and edge detect
	//////////////////////////////

	// lines idle high.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			clk_sync <= '1;
			data_sync <= '1;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[LAST_STAGE-1:0], ps2_clk};
			data_sync <= {data_sync[LAST_STAGE-1:0], ps2_data};
			clk_prev <= clk_sync[LAST_STAGE];
		end
	end

	assign fall = clk_prev & ~clk_sync[LAST_STAGE];
	assign data_bit = data_sync[LAST_STAGE];

	//////////////////////////////
	// frame shifter
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bit_cnt <= '0;
		end else if (fall) begin
			bit_cnt <= (bit_cnt == 4'(LAST_BIT)) ? 4'd0 : bit_cnt + 4'd1;
		end
	end

	// lsb first, so after ten bits shift[0] holds the start bit.
	always_ff @(posedge clk) begin
		if (fall && bit_cnt != 4'(LAST_BIT)) begin
			shift <= {data_bit, shift[`PS2_FRAME_BITS-2:1]};
		end
	end

	// the stop bit is checked straight off the synchroniser.
	assign frame_end = fall && (bit_cnt == 4'(LAST_BIT));
	assign framing_ok = ~shift[0] & data_bit;
	assign parity_ok = ^shift[`PS2_FRAME_BITS-2:1];

	// a bad start bit is reported as a framing error on stop_err.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			frame.frame_valid <= 1'b0;
			frame.parity_err <= 1'b0;
			frame.stop_err <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			frame.frame_valid <= frame_end & framing_ok & parity_ok;
			frame.parity_err <= frame_end & framing_ok & ~parity_ok;
			frame.stop_err <= frame_end & ~framing_ok;
			rx_error <= frame_end & ~(framing_ok & parity_ok);
		end
	end

	always_ff @(posedge clk) begin
		if (frame_end) begin
			frame.code <= shift[8:1];
		end
	end

	a_single_strobe: assert property (@(posedge clk) disable iff (!resetn)
		(frame.frame_valid || frame.parity_err || frame.stop_err)
		|=> !(frame.frame_valid || frame.parity_err || frame.stop_err));

	a_bit_cnt_range: assert property (@(posedge clk) disable iff (!resetn)
		bit_cnt <= 4'(LAST_BIT));

endmodule

/* design/ps2_frame_if.sv */
`timescale 1ns/10ps

interface ps2_frame_if import ps2_pkg::*; ();

	// at most one of the three strobes is high in any cycle.
	logic       frame_valid;
	scan_code_t code;
	logic       parity_err;
	logic       stop_err;

	modport rx (
		output frame_valid,
		output code,
		output parity_err,
		output stop_err
	);

	modport sink (
		input frame_valid,
		input code,
		input parity_err,
		input stop_err
	);

endinterface

/* design/ps2_pkg.sv */
package ps2_pkg;

	//////////////////////////////
	// key data
	//////////////////////////////

	typedef logic [7:0] scan_code_t;

	// zero for keys without a printable value.
	typedef logic [7:0] ascii_t;

	// wraps past 255.
	typedef logic [7:0] press_count_t;

	// break states mean an F0 arrived and the next code is a release.
	typedef enum logic [1:0] {
		track_idle       = 2'd0,
		track_held       = 2'd1,
		track_break_idle = 2'd2,
		track_break_held = 2'd3
	} tracker_state_e;

	//////////////////////////////
	// display
	//////////////////////////////

	// bit 0 is segment a, bit 6 is segment g.
	typedef logic [6:0] seg_pattern_t;

endpackage

/* design/ps2_defines.svh */
`ifndef PS2_DEFINES_SVH
`define PS2_DEFINES_SVH

//////////////////////////////
// ps/2 frame format
//////////////////////////////

// flops on each keyboard line.
`define PS2_SYNC_STAGES 3

// start, eight data, parity, stop.
`define PS2_FRAME_BITS 11

`define PS2_BREAK_CODE 8'hF0
`define PS2_EXT_CODE 8'hE0

// two digits each for scan code, ascii and count.
`define SEG_DIGITS 6

`endif
